//--- compile.f
+incdir+source
source/memSystemPkg.sv
source/cacheWay.sv
source/waySteering.sv
source/cacheController.sv
source/bankedMemory.sv
source/memSystem.sv
verification/memSystemTb.sv

//--- source/bankedMemory.sv
// four 8K-word banks with a two-cycle read and contents zeroed by a simulation-only initial
`timescale 1ns/1ps
`include "memSystem_defines.svh"

module bankedMemory import memSystemPkg::*; (
   input  logic                  clk,
   input  logic                  memRd,
   input  logic                  memWr,
   input  addrWord_u             memAddr,
   input  logic [`MS_DATA_W-1:0] writeData,
   output logic [`MS_DATA_W-1:0] readData
);

   localparam int bankDepth = 2 ** (`MS_TAG_W + `MS_INDEX_W);

   logic [`MS_DATA_W-1:0]            bankMem  [`MS_WORDS][bankDepth];
   logic [`MS_DATA_W-1:0]            readPipe [`MS_READ_LAT];
   logic [1:0]                       bankSel;
   logic [`MS_TAG_W+`MS_INDEX_W-1:0] bankRow;

   // word offset picks the bank
   // so one line spreads over all four
   assign bankSel = memAddr.fields.offset[`MS_OFFSET_W-1:1];
   assign bankRow = {memAddr.fields.tag, memAddr.fields.index};

   // memory starts out all zero
   initial begin
      for (int b = 0; b < `MS_WORDS; b++) begin
         for (int r = 0; r < bankDepth; r++) begin
            bankMem[b][r] = '0;
         end
      end
   end

   always @(posedge clk) begin
      if (memWr) begin
         bankMem[bankSel][bankRow] <= writeData;
      end
   end

   // ##############################
   // read pipeline
   // ##############################

   // a new read may enter every cycle
   always_ff @(posedge clk) begin
      if (memRd) begin
         readPipe[0] <= bankMem[bankSel][bankRow];
      end
      for (int s = 1; s < `MS_READ_LAT; s++) begin
         readPipe[s] <= readPipe[s-1];
      end
   end

   assign readData = readPipe[`MS_READ_LAT-1];

endmodule

//--- source/cacheController.sv
// request FSM for a fixed two-cycle memory with no stall and a request held level until done
`timescale 1ns/1ps
`include "memSystem_defines.svh"

module cacheController import memSystemPkg::*; (
   input  logic                 clk,
   input  logic                 arstN,
   input  addrWord_u            addr,
   input  logic                 rd,
   input  logic                 wr,
   input  logic                 anyHit,
   input  logic                 victimDirty,
   input  logic [`MS_TAG_W-1:0] victimTag,
   output logic                 done,
   output logic                 stall,
   output logic                 cacheHit,
   output logic                 lockWay,
   output logic                 complete,
   output logic                 wayEnable,
   output logic                 compare,
   output logic                 wayWrite,
   output logic                 fill,
   output addrWord_u            lineAddr,
   output logic                 memRd,
   output logic                 memWr,
   output addrWord_u            memAddr
);

   // ##############################
   // state codes
   // ##############################

   localparam logic [3:0] stIdle       = 4'd0;
   localparam logic [3:0] stCompRd     = 4'd1;
   localparam logic [3:0] stCompWr     = 4'd2;
   localparam logic [3:0] stFinalWr    = 4'd3;
   // evict states 4..7 so the low bits are the word
   localparam logic [3:0] stEvict0     = 4'd4;
   localparam logic [3:0] stEvict1     = 4'd5;
   localparam logic [3:0] stEvict2     = 4'd6;
   localparam logic [3:0] stEvict3     = 4'd7;
   localparam logic [3:0] stRead0      = 4'd8;
   localparam logic [3:0] stRead1      = 4'd9;
   localparam logic [3:0] stWriteDone  = 4'd10;
   localparam logic [3:0] stDone       = 4'd11;
   // fill states 12..15 so the low bits again give the word
   localparam logic [3:0] stRead2Fill0 = 4'd12;
   localparam logic [3:0] stRead3Fill1 = 4'd13;
   localparam logic [3:0] stFill2      = 4'd14;
   localparam logic [3:0] stFill3      = 4'd15;

   logic [3:0] state;
   logic [3:0] nextState;
   logic [3:0] reqState;
   logic       reqValid;
   logic       lineStep;
   logic       useVictimTag;
   logic [1:0] memWord;

   // exactly one of rd and wr makes a request
   assign reqValid = rd ^ wr;
   assign reqState = rd ? stCompRd : stCompWr;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state <= stIdle;
      end else begin
         state <= nextState;
      end
   end

   always_comb begin
      nextState    = state;
      done         = 1'b0;
      stall        = 1'b1;
      cacheHit     = 1'b0;
      lockWay      = 1'b0;
      complete     = 1'b0;
      wayEnable    = 1'b1;
      compare      = 1'b0;
      wayWrite     = 1'b0;
      fill         = 1'b0;
      memRd        = 1'b0;
      memWr        = 1'b0;
      lineStep     = 1'b0;
      useVictimTag = 1'b0;
      memWord      = 2'd0;
      case (state)
         stIdle: begin
            stall     = 1'b0;
            wayEnable = reqValid;
            lockWay   = reqValid;
            nextState = reqValid ? reqState : stIdle;
         end
         stCompRd, stCompWr: begin
            // write lands only if the held way hits
            compare   = 1'b1;
            wayWrite  = (state == stCompWr);
            nextState = anyHit ? stDone : (victimDirty ? stEvict0 : stRead0);
         end
         stEvict0, stEvict1, stEvict2, stEvict3: begin
            // push the dirty victim out a word per cycle
            memWr        = 1'b1;
            lineStep     = 1'b1;
            useVictimTag = 1'b1;
            memWord      = state[1:0];
            nextState    = (state == stEvict3) ? stRead0 : state + 4'd1;
         end
         stRead0, stRead1: begin
            // ways idle while the first reads are in flight
            wayEnable = 1'b0;
            memRd     = 1'b1;
            memWord   = state[1:0];
            nextState = (state == stRead0) ? stRead1 : stRead2Fill0;
         end
         stRead2Fill0, stRead3Fill1: begin
            // last two reads overlap the first two fill writes
            memRd     = 1'b1;
            memWord   = {1'b1, state[0]};
            wayWrite  = 1'b1;
            fill      = 1'b1;
            lineStep  = 1'b1;
            nextState = state + 4'd1;
         end
         stFill2, stFill3: begin
            wayWrite  = 1'b1;
            fill      = 1'b1;
            lineStep  = 1'b1;
            // write miss still owes its word
            nextState = (state == stFill2) ? stFill3 : (wr ? stFinalWr : stWriteDone);
         end
         stFinalWr: begin
            compare   = 1'b1;
            wayWrite  = 1'b1;
            nextState = stWriteDone;
         end
         stWriteDone, stDone: begin
            // a new request chains straight in from here
            done      = 1'b1;
            stall     = 1'b0;
            cacheHit  = (state == stDone);
            complete  = 1'b1;
            lockWay   = reqValid;
            nextState = reqValid ? reqState : stIdle;
         end
         default: begin
            nextState = stIdle;
         end
      endcase
   end

   // ##############################
   // address steering
   // ##############################

   always_comb begin
      lineAddr = addr;
      // evict and fill walk the line word by word
      if (lineStep) begin
         lineAddr.fields.offset = {state[1:0], 1'b0};
      end
      memAddr = addr;
      memAddr.fields.offset = {memWord, 1'b0};
      // write-back goes to where the victim came from
      if (useVictimTag) begin
         memAddr.fields.tag = victimTag;
      end
   end

endmodule

//--- source/cacheWay.sv
// one cache way of 256 lines with combinational reads and only the valid bits cleared by reset
`timescale 1ns/1ps
`include "memSystem_defines.svh"

module cacheWay import memSystemPkg::*; (
   input  logic                  clk,
   input  logic                  arstN,
   input  logic                  wayEnable,
   input  logic                  compare,
   input  logic                  write,
   input  logic                  fill,
   input  addrWord_u             lineAddr,
   input  logic [`MS_DATA_W-1:0] writeData,
   output logic                  hit,
   output logic                  valid,
   output logic                  dirty,
   output logic [`MS_TAG_W-1:0]  tagOut,
   output logic [`MS_DATA_W-1:0] wordOut
);

   localparam int numSets = 2 ** `MS_INDEX_W;

   // ##############################
   // line storage
   // ##############################

   logic [`MS_TAG_W-1:0]   tagArr   [numSets];
   logic [numSets-1:0]     validArr;
   logic                   dirtyArr [numSets];
   logic [`MS_DATA_W-1:0]  dataArr  [numSets][`MS_WORDS];

   logic [`MS_INDEX_W-1:0] setIdx;
   logic [1:0]             wordSel;
   logic                   tagMatch;
   logic                   cmpWrite;
   logic                   fillWrite;

   // set from the index field
   assign setIdx  = lineAddr.fields.index;
   // word within the line with the byte bit dropped
   assign wordSel = lineAddr.fields.offset[`MS_OFFSET_W-1:1];

   // status of the addressed line
   assign valid   = validArr[setIdx];
   assign dirty   = dirtyArr[setIdx];
   assign tagOut  = tagArr[setIdx];
   assign wordOut = dataArr[setIdx][wordSel];

   assign tagMatch = (tagOut == lineAddr.fields.tag);
   // an invalid line never hits whatever its stale tag says
   assign hit      = wayEnable & valid & tagMatch;

   // compare-write only lands on a hit
   assign cmpWrite  = write & compare & ~fill & hit;
   // fill writes regardless of the old tag
   assign fillWrite = wayEnable & write & fill;

   // ##############################
   // updates
   // ##############################

   // a filled line becomes valid
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         validArr <= '0;
      end else if (fillWrite) begin
         validArr[setIdx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fillWrite || cmpWrite) begin
         dataArr[setIdx][wordSel] <= writeData;
      end
      if (fillWrite) begin
         // line now mirrors memory
         tagArr[setIdx]   <= lineAddr.fields.tag;
         dirtyArr[setIdx] <= 1'b0;
      end else if (cmpWrite) begin
         // cached copy now differs from memory
         dirtyArr[setIdx] <= 1'b1;
      end
   end

endmodule

//--- source/memSystem.sv
// two-way write-back cache in front of banked memory where the requester holds rd or wr until done
`timescale 1ns/1ps
`include "memSystem_defines.svh"

module memSystem import memSystemPkg::*; (
   input  logic                  clk,
   input  logic                  arstN,
   input  addrWord_u             addr,
   input  logic [`MS_DATA_W-1:0] dataIn,
   input  logic                  rd,
   input  logic                  wr,
   output logic [`MS_DATA_W-1:0] dataOut,
   output logic                  done,
   output logic                  stall,
   output logic                  cacheHit
);

   // controller to ways and steering
   logic                  lockWay;
   logic                  complete;
   logic                  wayEnable;
   logic                  compare;
   logic                  wayWrite;
   logic                  fill;
   addrWord_u             lineAddr;
   // controller to memory
   logic                  memRd;
   logic                  memWr;
   addrWord_u             memAddr;
   logic [`MS_DATA_W-1:0] memData;
   logic [`MS_DATA_W-1:0] evictWord;
   // steering back to controller
   logic                  anyHit;
   logic                  victimDirty;
   logic [`MS_TAG_W-1:0]  victimTag;
   // per-way status and write path
   logic                  hit0;
   logic                  hit1;
   logic                  valid0;
   logic                  valid1;
   logic                  dirty0;
   logic                  dirty1;
   logic [`MS_TAG_W-1:0]  tag0;
   logic [`MS_TAG_W-1:0]  tag1;
   logic [`MS_DATA_W-1:0] word0;
   logic [`MS_DATA_W-1:0] word1;
   logic                  write0;
   logic                  write1;
   logic [`MS_DATA_W-1:0] writeData0;
   logic [`MS_DATA_W-1:0] writeData1;

   cacheController u_controller (
      .clk(clk), .arstN(arstN), .addr(addr), .rd(rd), .wr(wr),
      .anyHit(anyHit), .victimDirty(victimDirty), .victimTag(victimTag),
      .done(done), .stall(stall), .cacheHit(cacheHit),
      .lockWay(lockWay), .complete(complete), .wayEnable(wayEnable),
      .compare(compare), .wayWrite(wayWrite), .fill(fill), .lineAddr(lineAddr),
      .memRd(memRd), .memWr(memWr), .memAddr(memAddr)
   );

   // ##############################
   // ways and steering
   // ##############################

   cacheWay u_way0 (
      .clk(clk), .arstN(arstN), .wayEnable(wayEnable), .compare(compare),
      .write(write0), .fill(fill), .lineAddr(lineAddr), .writeData(writeData0),
      .hit(hit0), .valid(valid0), .dirty(dirty0), .tagOut(tag0), .wordOut(word0)
   );

   cacheWay u_way1 (
      .clk(clk), .arstN(arstN), .wayEnable(wayEnable), .compare(compare),
      .write(write1), .fill(fill), .lineAddr(lineAddr), .writeData(writeData1),
      .hit(hit1), .valid(valid1), .dirty(dirty1), .tagOut(tag1), .wordOut(word1)
   );

   waySteering u_steering (
      .clk(clk), .arstN(arstN), .lockWay(lockWay), .complete(complete),
      .wayWrite(wayWrite), .fill(fill),
      .hit0(hit0), .hit1(hit1), .valid0(valid0), .valid1(valid1),
      .dirty0(dirty0), .dirty1(dirty1), .tag0(tag0), .tag1(tag1),
      .word0(word0), .word1(word1), .dataIn(dataIn), .memData(memData),
      .anyHit(anyHit), .victimDirty(victimDirty), .victimTag(victimTag),
      .evictWord(evictWord), .dataOut(dataOut), .write0(write0), .write1(write1),
      .writeData0(writeData0), .writeData1(writeData1)
   );

   // write-back data always comes from the held way
   bankedMemory u_memory (
      .clk(clk), .memRd(memRd), .memWr(memWr), .memAddr(memAddr),
      .writeData(evictWord), .readData(memData)
   );

endmodule

//--- source/memSystemPkg.sv
// address layout shared by cache, memory and testbench with widths from the defines header
`include "memSystem_defines.svh"

package memSystemPkg;

   // ##############################
   // address word views
   // ##############################

   // cache view of a byte address
   // tag sits on top and offset at the bottom
   typedef struct packed {
      logic [`MS_TAG_W-1:0]    tag;
      logic [`MS_INDEX_W-1:0]  index;
      logic [`MS_OFFSET_W-1:0] offset;
   } addrFields_s;

   // one 16-bit word decoded two ways
   // raw is what main memory sees
   // fields is what the cache ways see
   typedef union packed {
      logic [`MS_TAG_W+`MS_INDEX_W+`MS_OFFSET_W-1:0] raw;
      addrFields_s                                   fields;
   } addrWord_u;

endpackage

//--- source/memSystem_defines.svh
// sizes are fixed by the 16-bit address split and the FSM assumes a read latency of 2
`ifndef MEM_SYSTEM_DEFINES_SVH
`define MEM_SYSTEM_DEFINES_SVH

// ##############################
// bus widths
// ##############################

// data word on the request side and the memory side
`define MS_DATA_W 16

// ##############################
// address split tag | index | offset
// ##############################

// tag bits above the set index
`define MS_TAG_W 5
// 256 sets per way
`define MS_INDEX_W 8
// byte offset within a line and bit 0 is ignored
`define MS_OFFSET_W 3
// words in one line
`define MS_WORDS 4

// fixed main memory read latency in cycles
`define MS_READ_LAT 2

`endif

//--- source/waySteering.sv
// two-way selection and steering that relies on lockWay pulsing before any way write
`timescale 1ns/1ps
`include "memSystem_defines.svh"

module waySteering (
   input  logic                  clk,
   input  logic                  arstN,
   input  logic                  lockWay,
   input  logic                  complete,
   input  logic                  wayWrite,
   input  logic                  fill,
   input  logic                  hit0,
   input  logic                  hit1,
   input  logic                  valid0,
   input  logic                  valid1,
   input  logic                  dirty0,
   input  logic                  dirty1,
   input  logic [`MS_TAG_W-1:0]  tag0,
   input  logic [`MS_TAG_W-1:0]  tag1,
   input  logic [`MS_DATA_W-1:0] word0,
   input  logic [`MS_DATA_W-1:0] word1,
   input  logic [`MS_DATA_W-1:0] dataIn,
   input  logic [`MS_DATA_W-1:0] memData,
   output logic                  anyHit,
   output logic                  victimDirty,
   output logic [`MS_TAG_W-1:0]  victimTag,
   output logic [`MS_DATA_W-1:0] evictWord,
   output logic [`MS_DATA_W-1:0] dataOut,
   output logic                  write0,
   output logic                  write1,
   output logic [`MS_DATA_W-1:0] writeData0,
   output logic [`MS_DATA_W-1:0] writeData1
);

   logic                  victimPtr;
   logic                  heldWay;
   logic                  pickWay;
   logic [`MS_DATA_W-1:0] heldWord;
   logic [`MS_DATA_W-1:0] wayData;

   // hit first, then a free way, then the pointer
   always_comb begin
      if (hit0) begin
         pickWay = 1'b0;
      end else if (hit1) begin
         pickWay = 1'b1;
      end else if (!valid0) begin
         pickWay = 1'b0;
      end else if (!valid1) begin
         pickWay = 1'b1;
      end else begin
         pickWay = victimPtr;
      end
   end

   // way is frozen for the whole request
   // pointer flips once per finished request
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         heldWay   <= 1'b0;
         victimPtr <= 1'b0;
      end else begin
         if (lockWay) begin
            heldWay <= pickWay;
         end
         if (complete) begin
            victimPtr <= ~victimPtr;
         end
      end
   end

   assign anyHit      = hit0 | hit1;
   assign victimDirty = heldWay ? (valid1 & dirty1) : (valid0 & dirty0);
   assign victimTag   = heldWay ? tag1 : tag0;

   // held way feeds both the requester and the write-back path
   assign heldWord  = heldWay ? word1 : word0;
   assign evictWord = heldWord;
   assign dataOut   = heldWord;

   // only the held way gets written
   assign write0 = wayWrite & ~heldWay;
   assign write1 = wayWrite & heldWay;

   // memory word during a fill and request word otherwise
   assign wayData    = fill ? memData : dataIn;
   assign writeData0 = wayData;
   assign writeData1 = wayData;

endmodule

//--- verification/memSystemTb.sv
// self-checking testbench where one request is in flight at a time and main memory starts at zero
`timescale 1ns/1ps
`include "memSystem_defines.svh"

module memSystemTb import memSystemPkg::*; ();

   localparam int clkPeriod     = 10;
   localparam int resetCycles   = 3;
   localparam int directedCount = 10;
   localparam int randomCount   = 400;
   localparam int cyclesPerReq  = 20;
   // longest request is a dirty write miss of 13 cycles
   localparam int maxLatency    = 16;
   localparam int numSets       = 2 ** `MS_INDEX_W;
   localparam int memWords      = 2 ** (`MS_TAG_W + `MS_INDEX_W + `MS_OFFSET_W - 1);

   logic                  clk;
   logic                  arstN;
   addrWord_u             addr;
   logic [`MS_DATA_W-1:0] dataIn;
   logic                  rd;
   logic                  wr;
   logic [`MS_DATA_W-1:0] dataOut;
   logic                  done;
   logic                  stall;
   logic                  cacheHit;

   // ##############################
   // reference cache model
   // ##############################

   bit                    mValid  [numSets][2];
   bit                    mDirty  [numSets][2];
   logic [`MS_TAG_W-1:0]  mTag    [numSets][2];
   logic [`MS_DATA_W-1:0] mData   [numSets][2][`MS_WORDS];
   logic [`MS_DATA_W-1:0] mainMem [memWords];
   bit                    mPtr;
   // tag of the line the last write-back pushed out
   logic [`MS_TAG_W-1:0]  evictedTag;

   memSystem u_memSystem (
      .clk(clk), .arstN(arstN), .addr(addr), .dataIn(dataIn), .rd(rd), .wr(wr),
      .dataOut(dataOut), .done(done), .stall(stall), .cacheHit(cacheHit)
   );

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   task automatic stopOnError(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic checkWord(input string name, input logic [`MS_DATA_W-1:0] got,
                            input logic [`MS_DATA_W-1:0] exp);
      if (got !== exp) begin
         stopOnError($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stopOnError($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   // empty cache, zeroed memory, pointer on way 0
   task automatic clearModel();
      for (int s = 0; s < numSets; s++) begin
         mValid[s][0] = 1'b0;
         mValid[s][1] = 1'b0;
         mDirty[s][0] = 1'b0;
         mDirty[s][1] = 1'b0;
      end
      for (int m = 0; m < memWords; m++) begin
         mainMem[m] = '0;
      end
      mPtr = 1'b0;
   endtask

   // applies one request to the model and returns what the DUT should show at done
   task automatic predictRequest(input logic isWrite, input addrWord_u a,
                                 input logic [`MS_DATA_W-1:0] d, input bit chained,
                                 output logic [`MS_DATA_W-1:0] expData,
                                 output logic expHit, output int expLatency);
      logic [`MS_INDEX_W-1:0] idx;
      logic [`MS_TAG_W-1:0]   tag;
      logic [1:0]             word;
      logic [2:0]             w;
      bit                     way;
      bit                     ptrSeen;
      idx  = a.fields.index;
      tag  = a.fields.tag;
      word = a.fields.offset[`MS_OFFSET_W-1:1];
      // a chained request locks its way on the same edge that flips the pointer
      ptrSeen = chained ? ~mPtr : mPtr;
      expHit  = 1'b1;
      if (mValid[idx][0] && mTag[idx][0] == tag) begin
         way = 1'b0;
      end else if (mValid[idx][1] && mTag[idx][1] == tag) begin
         way = 1'b1;
      end else begin
         expHit = 1'b0;
         if (!mValid[idx][0]) begin
            way = 1'b0;
         end else if (!mValid[idx][1]) begin
            way = 1'b1;
         end else begin
            way = ptrSeen;
         end
      end
      if (expHit) begin
         expLatency = 2;
      end else begin
         // write miss owes one more compare-write cycle
         expLatency = isWrite ? 9 : 8;
         if (mValid[idx][way] && mDirty[idx][way]) begin
            expLatency += 4;
            evictedTag = mTag[idx][way];
            for (w = 0; w < `MS_WORDS; w++) begin
               mainMem[{mTag[idx][way], idx, w[1:0]}] = mData[idx][way][w];
            end
         end
         for (w = 0; w < `MS_WORDS; w++) begin
            mData[idx][way][w] = mainMem[{tag, idx, w[1:0]}];
         end
         mValid[idx][way] = 1'b1;
         mDirty[idx][way] = 1'b0;
         mTag[idx][way]   = tag;
      end
      if (isWrite) begin
         mData[idx][way][word] = d;
         mDirty[idx][way]      = 1'b1;
      end
      expData = mData[idx][way][word];
      mPtr    = ~mPtr;
   endtask

   // ##############################
   // request driver
   // ##############################

   // called 1 ns after an edge while idle or in the previous done cycle
   task automatic runRequest(input logic isWrite, input addrWord_u a,
                             input logic [`MS_DATA_W-1:0] d, input bit chained);
      logic [`MS_DATA_W-1:0] expData;
      logic                  expHit;
      int                    expLatency;
      int                    cycles;
      predictRequest(isWrite, a, d, chained, expData, expHit, expLatency);
      addr   = a;
      dataIn = d;
      rd     = ~isWrite;
      wr     = isWrite;
      cycles = 0;
      do begin
         @(posedge clk);
         #1;
         cycles++;
         if (!done) begin
            checkFlag("stall", stall, 1'b1);
            checkFlag("cacheHit", cacheHit, 1'b0);
            if (cycles > maxLatency) begin
               stopOnError($sformatf("request to 0x%h never raised done", a.raw));
            end
         end
      end while (!done);
      if (cycles != expLatency) begin
         stopOnError($sformatf("request to 0x%h took %0d cycles instead of %0d",
                               a.raw, cycles, expLatency));
      end
      checkFlag("stall", stall, 1'b0);
      checkFlag("cacheHit", cacheHit, expHit);
      checkWord("dataOut", dataOut, expData);
   endtask

   // leave the done cycle with no request so the FSM falls back to idle
   task automatic dropRequest();
      rd = 1'b0;
      wr = 1'b0;
      @(posedge clk);
      #1;
      checkFlag("done", done, 1'b0);
   endtask

   function automatic logic [`MS_INDEX_W-1:0] randomIndex();
      case ($urandom % 4)
         0:       return 8'h03;
         1:       return 8'h47;
         2:       return 8'h9c;
         default: return 8'hf0;
      endcase
   endfunction

   // six tags over four sets keeps both ways under pressure
   function automatic logic [`MS_TAG_W-1:0] randomTag();
      case ($urandom % 6)
         0:       return 5'h00;
         1:       return 5'h05;
         2:       return 5'h0a;
         3:       return 5'h11;
         4:       return 5'h1c;
         default: return 5'h1f;
      endcase
   endfunction

   // ##############################
   // main sequence
   // ##############################

   initial begin
      addrWord_u             a;
      logic [`MS_DATA_W-1:0] d;
      logic                  isWrite;
      logic [1:0]            word;
      int                    n;
      void'($urandom(32'h8923));
      rd         = 1'b0;
      wr         = 1'b0;
      addr       = '0;
      dataIn     = '0;
      arstN      = 1'b0;
      clearModel();
      repeat (resetCycles) @(posedge clk);
      #1;
      arstN = 1'b1;

      // quiet outputs with nothing requested
      repeat (5) begin
         @(posedge clk);
         #1;
         checkFlag("done", done, 1'b0);
         checkFlag("stall", stall, 1'b0);
         checkFlag("cacheHit", cacheHit, 1'b0);
      end

      // cold read miss, then the same word again as a hit
      a.raw          = '0;
      a.fields.tag   = 5'h02;
      a.fields.index = 8'h10;
      a.fields.offset = 3'd2;
      runRequest(1'b0, a, 16'h0000, 1'b0);
      runRequest(1'b0, a, 16'h0000, 1'b1);
      // write hit and read back
      runRequest(1'b1, a, 16'hbeef, 1'b1);
      runRequest(1'b0, a, 16'h0000, 1'b1);
      dropRequest();

      // two dirty lines in one set, then a third tag pushes one out
      a.fields.index  = 8'h5a;
      a.fields.offset = 3'd4;
      a.fields.tag    = 5'h01;
      runRequest(1'b1, a, 16'h1234, 1'b0);
      a.fields.tag = 5'h09;
      runRequest(1'b1, a, 16'h5678, 1'b1);
      a.fields.tag = 5'h15;
      runRequest(1'b0, a, 16'h0000, 1'b1);
      // evicted word must come back from memory
      a.fields.tag = evictedTag;
      runRequest(1'b0, a, 16'h0000, 1'b1);
      dropRequest();

      // random back-to-back traffic
      for (n = 0; n < randomCount; n++) begin
         word            = $urandom;
         a.raw           = '0;
         a.fields.tag    = randomTag();
         a.fields.index  = randomIndex();
         a.fields.offset = {word, 1'b0};
         isWrite         = $urandom % 2;
         d               = $urandom;
         runRequest(isWrite, a, d, n != 0);
      end
      dropRequest();

      $display("Simulation completed successfully");
      $finish;
   end

   // budget of cycles per request on top of reset and idle gaps
   initial begin
      #((resetCycles + 20 + (directedCount + randomCount) * cyclesPerReq) * clkPeriod);
      stopOnError($sformatf("run timed out at %0t before all requests finished", $time));
   end

endmodule
